//--- compile.f
hw/periph_pkg.sv
hw/reg_decode.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_regs.sv
hw/irq_ctrl.sv
hw/periph_top.sv
testbench/tb_periph.sv

//--- hw/irq_ctrl.sv
`timescale 1ns/1ps

module irq_ctrl
  import periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  addr_t                  ofs_i,
  input  data_t                  wdata_i,
  input  logic [NUM_SOURCES-1:0] src_i,
  output data_t                  rdata_o,
  output logic                   hit_o,
  output logic [NUM_TARGETS-1:0] irq_o
);

  // id 0 is never a real source
  localparam logic [NUM_SOURCES-1:0] SRC_MASK = ~NUM_SOURCES'(1);

  prio_t                  prio_q   [NUM_SOURCES];
  logic [NUM_SOURCES-1:0] enable_q [NUM_TARGETS];
  prio_t                  thresh_q [NUM_TARGETS];
  logic [NUM_SOURCES-1:0] pending_q;
  logic [NUM_SOURCES-1:0] in_service_q;

  logic [NUM_SOURCES-1:0] prio_sel;
  logic [NUM_TARGETS-1:0] en_sel;
  logic [NUM_TARGETS-1:0] th_sel;
  logic [NUM_TARGETS-1:0] claim_sel;
  logic [NUM_SOURCES-1:0] claim_clr;
  logic [NUM_SOURCES-1:0] done_clr;
  src_id_t                best_id   [NUM_TARGETS];
  prio_t                  best_prio [NUM_TARGETS];

  // --------------------
  // best candidate
  // --------------------
  // strict compare keeps the lowest id on a tie
  always_comb begin
    for (int t = 0; t < NUM_TARGETS; t++) begin
      best_id[t]   = '0;
      best_prio[t] = thresh_q[t];
      for (int s = 1; s < NUM_SOURCES; s++) begin
        if (pending_q[s] && enable_q[t][s] && prio_q[s] > best_prio[t]) begin
          best_prio[t] = prio_q[s];
          best_id[t]   = src_id_t'(s);
        end
      end
      irq_o[t] = (best_id[t] != '0);
    end
  end

  // --------------------
  // register decode
  // --------------------
  always_comb begin
    hit_o     = 1'b0;
    rdata_o   = '0;
    prio_sel  = '0;
    en_sel    = '0;
    th_sel    = '0;
    claim_sel = '0;
    for (int i = 0; i < NUM_SOURCES; i++) begin
      if (ofs_i == PRIO_OFS + addr_t'(4 * i)) begin
        hit_o       = 1'b1;
        prio_sel[i] = 1'b1;
        rdata_o     = data_t'(prio_q[i]);
      end
    end
    for (int t = 0; t < NUM_TARGETS; t++) begin
      if (ofs_i == ENABLE_OFS + addr_t'(4 * t)) begin
        hit_o     = 1'b1;
        en_sel[t] = 1'b1;
        rdata_o   = data_t'(enable_q[t]);
      end
      if (ofs_i == THRESH_OFS + addr_t'(4 * t)) begin
        hit_o     = 1'b1;
        th_sel[t] = 1'b1;
        rdata_o   = data_t'(thresh_q[t]);
      end
      if (ofs_i == CLAIM_OFS + addr_t'(4 * t)) begin
        hit_o        = 1'b1;
        claim_sel[t] = 1'b1;
        rdata_o      = data_t'(best_id[t]);
      end
    end
  end

  // claim read takes the best id, claim write completes an id
  always_comb begin
    claim_clr = '0;
    done_clr  = '0;
    for (int t = 0; t < NUM_TARGETS; t++) begin
      if (req_i && claim_sel[t]) begin
        if (we_i) begin
          done_clr[src_id_t'(wdata_i)] = 1'b1;
        end else begin
          claim_clr[best_id[t]] = 1'b1;
        end
      end
    end
  end

  // --------------------
  // state
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q    <= '0;
      in_service_q <= '0;
      for (int i = 0; i < NUM_SOURCES; i++) begin
        prio_q[i] <= '0;
      end
      for (int t = 0; t < NUM_TARGETS; t++) begin
        enable_q[t] <= '0;
        thresh_q[t] <= '0;
      end
    end else begin
      // level sources, held off while in service
      pending_q    <= (pending_q | (src_i & ~in_service_q)) & ~claim_clr & SRC_MASK;
      in_service_q <= (in_service_q | claim_clr) & ~done_clr & SRC_MASK;
      // prio of id 0 stays zero
      for (int i = 1; i < NUM_SOURCES; i++) begin
        if (req_i && we_i && prio_sel[i]) begin
          prio_q[i] <= prio_t'(wdata_i);
        end
      end
      for (int t = 0; t < NUM_TARGETS; t++) begin
        if (req_i && we_i && en_sel[t]) begin
          enable_q[t] <= wdata_i[NUM_SOURCES-1:0] & SRC_MASK;
        end
        if (req_i && we_i && th_sel[t]) begin
          thresh_q[t] <= prio_t'(wdata_i);
        end
      end
    end
  end

endmodule

//--- hw/periph_pkg.sv
package periph_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int ADDR_W = 12;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [31:0]       data_t;
  typedef logic [7:0]        byte_t;
  // uart bit time in clocks
  typedef logic [15:0]       div_t;
  // 0 means never
  typedef logic [2:0]        prio_t;
  // 0 means no source
  typedef logic [1:0]        src_id_t;

  // --------------------
  // sizes
  // --------------------
  // id slots incl. the unused id 0
  localparam int NUM_SOURCES = 4;
  localparam int NUM_TARGETS = 2;
  localparam div_t DIV_RESET = 16'd16;
  // low address bits are the offset inside a region
  localparam int REGION_BITS = 8;

  // --------------------
  // register map
  // --------------------
  localparam addr_t PLIC_BASE  = 12'h000;
  localparam addr_t PRIO_OFS   = 12'h000;
  localparam addr_t ENABLE_OFS = 12'h040;
  localparam addr_t THRESH_OFS = 12'h080;
  localparam addr_t CLAIM_OFS  = 12'h0C0;

  localparam addr_t UART_BASE  = 12'h100;
  localparam addr_t TXDATA_OFS = 12'h000;
  localparam addr_t RXDATA_OFS = 12'h004;
  localparam addr_t STATUS_OFS = 12'h008;
  localparam addr_t DIV_OFS    = 12'h00C;
  localparam addr_t IRQEN_OFS  = 12'h010;

  // fsm states
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

//--- hw/periph_top.sv
`timescale 1ns/1ps

module periph_top
  import periph_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  // register bus
  input  logic                   bus_req_i,
  input  logic                   bus_we_i,
  input  addr_t                  bus_addr_i,
  input  data_t                  bus_wdata_i,
  output logic                   bus_rvalid_o,
  output data_t                  bus_rdata_o,
  output logic                   bus_err_o,
  // serial lines
  input  logic                   rx_i,
  output logic                   tx_o,
  // interrupts
  input  logic [1:0]             ext_irq_i,
  output logic [NUM_TARGETS-1:0] irq_o
);

  logic  plic_req;
  logic  uart_req;
  logic  we;
  addr_t ofs;
  data_t wdata;
  data_t plic_rdata;
  data_t uart_rdata;
  logic  plic_hit;
  logic  uart_hit;
  logic  uart_irq;

  // --------------------
  // decode stage
  // --------------------
  reg_decode i_reg_decode (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .bus_req_i    ( bus_req_i    ),
    .bus_we_i     ( bus_we_i     ),
    .bus_addr_i   ( bus_addr_i   ),
    .bus_wdata_i  ( bus_wdata_i  ),
    .bus_rvalid_o ( bus_rvalid_o ),
    .bus_rdata_o  ( bus_rdata_o  ),
    .bus_err_o    ( bus_err_o    ),
    .plic_req_o   ( plic_req     ),
    .uart_req_o   ( uart_req     ),
    .we_o         ( we           ),
    .ofs_o        ( ofs          ),
    .wdata_o      ( wdata        ),
    .plic_rdata_i ( plic_rdata   ),
    .uart_rdata_i ( uart_rdata   ),
    .plic_hit_i   ( plic_hit     ),
    .uart_hit_i   ( uart_hit     )
  );

  // --------------------
  // peripherals
  // --------------------
  uart_regs i_uart_regs (
    .clk_i   ( clk_i      ),
    .reset_i ( reset_i    ),
    .req_i   ( uart_req   ),
    .we_i    ( we         ),
    .ofs_i   ( ofs        ),
    .wdata_i ( wdata      ),
    .rx_i    ( rx_i       ),
    .rdata_o ( uart_rdata ),
    .hit_o   ( uart_hit   ),
    .tx_o    ( tx_o       ),
    .irq_o   ( uart_irq   )
  );

  // uart rx at source 1, external lines at 2 and 3
  irq_ctrl i_irq_ctrl (
    .clk_i   ( clk_i                         ),
    .reset_i ( reset_i                       ),
    .req_i   ( plic_req                      ),
    .we_i    ( we                            ),
    .ofs_i   ( ofs                           ),
    .wdata_i ( wdata                         ),
    .src_i   ( {ext_irq_i, uart_irq, 1'b0}   ),
    .rdata_o ( plic_rdata                    ),
    .hit_o   ( plic_hit                      ),
    .irq_o   ( irq_o                         )
  );

endmodule

//--- hw/reg_decode.sv
`timescale 1ns/1ps

module reg_decode
  import periph_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  // core side
  input  logic  bus_req_i,
  input  logic  bus_we_i,
  input  addr_t bus_addr_i,
  input  data_t bus_wdata_i,
  output logic  bus_rvalid_o,
  output data_t bus_rdata_o,
  output logic  bus_err_o,
  // peripheral side
  output logic  plic_req_o,
  output logic  uart_req_o,
  output logic  we_o,
  output addr_t ofs_o,
  output data_t wdata_o,
  input  data_t plic_rdata_i,
  input  data_t uart_rdata_i,
  input  logic  plic_hit_i,
  input  logic  uart_hit_i
);

  logic  plic_sel;
  logic  uart_sel;
  logic  hit;
  data_t sel_rdata;

  // --------------------
  // decode stage
  // --------------------
  // region from the upper address bits
  assign plic_sel = (bus_addr_i[ADDR_W-1:REGION_BITS] == PLIC_BASE[ADDR_W-1:REGION_BITS]);
  assign uart_sel = (bus_addr_i[ADDR_W-1:REGION_BITS] == UART_BASE[ADDR_W-1:REGION_BITS]);

  assign plic_req_o = bus_req_i & plic_sel;
  assign uart_req_o = bus_req_i & uart_sel;
  assign we_o       = bus_we_i;
  assign wdata_o    = bus_wdata_i;
  // offset inside the region
  assign ofs_o      = addr_t'(bus_addr_i[REGION_BITS-1:0]);

  // unmapped region counts as a miss
  always_comb begin
    hit       = 1'b0;
    sel_rdata = '0;
    if (plic_sel) begin
      hit       = plic_hit_i;
      sel_rdata = plic_rdata_i;
    end else if (uart_sel) begin
      hit       = uart_hit_i;
      sel_rdata = uart_rdata_i;
    end
  end

  // --------------------
  // response
  // --------------------
  // one response per request, one cycle later
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bus_rvalid_o <= 1'b0;
      bus_err_o    <= 1'b0;
      bus_rdata_o  <= '0;
    end else begin
      bus_rvalid_o <= bus_req_i;
      bus_err_o    <= bus_req_i & ~hit;
      // zero for writes and misses
      bus_rdata_o  <= (bus_req_i && !bus_we_i && hit) ? sel_rdata : '0;
    end
  end

endmodule

//--- hw/uart_regs.sv
`timescale 1ns/1ps

module uart_regs
  import periph_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_t ofs_i,
  input  data_t wdata_i,
  input  logic  rx_i,
  output data_t rdata_o,
  output logic  hit_o,
  output logic  tx_o,
  output logic  irq_o
);

  logic  tx_start;
  byte_t tx_byte;
  logic  tx_busy;
  logic  rx_done;
  byte_t rx_byte;

  div_t  div_q;
  byte_t rx_data_q;
  logic  rx_valid_q;
  logic  rx_ovr_q;
  logic  irq_en_q;
  logic  rd_rx;

  // --------------------
  // register access
  // --------------------
  // a busy transmitter drops the byte itself
  assign tx_start = req_i & we_i & (ofs_i == TXDATA_OFS);
  assign tx_byte  = wdata_i[7:0];
  assign rd_rx    = req_i & ~we_i & (ofs_i == RXDATA_OFS);

  always_comb begin
    hit_o   = 1'b1;
    rdata_o = '0;
    case (ofs_i)
      TXDATA_OFS: rdata_o = '0;
      RXDATA_OFS: rdata_o = data_t'(rx_data_q);
      STATUS_OFS: rdata_o = data_t'({rx_ovr_q, rx_valid_q, tx_busy});
      DIV_OFS:    rdata_o = data_t'(div_q);
      IRQEN_OFS:  rdata_o = data_t'(irq_en_q);
      default:    hit_o   = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      div_q      <= DIV_RESET;
      irq_en_q   <= 1'b0;
      rx_valid_q <= 1'b0;
      rx_ovr_q   <= 1'b0;
    end else begin
      if (req_i && we_i && ofs_i == DIV_OFS) begin
        div_q <= wdata_i[15:0];
      end
      if (req_i && we_i && ofs_i == IRQEN_OFS) begin
        irq_en_q <= wdata_i[0];
      end
      // rxdata read clears both flags
      if (rd_rx) begin
        rx_valid_q <= 1'b0;
        rx_ovr_q   <= 1'b0;
      end
      // new byte wins over a same cycle read
      if (rx_done) begin
        rx_valid_q <= 1'b1;
        if (rx_valid_q && !rd_rx) begin
          rx_ovr_q <= 1'b1;
        end
      end
    end
  end

  // received byte, replaced on overrun
  always_ff @(posedge clk_i) begin
    if (rx_done) begin
      rx_data_q <= rx_byte;
    end
  end

  assign irq_o = rx_valid_q & irq_en_q;

  // --------------------
  // serial engines
  // --------------------
  uart_tx i_uart_tx (
    .clk_i   ( clk_i    ),
    .reset_i ( reset_i  ),
    .start_i ( tx_start ),
    .byte_i  ( tx_byte  ),
    .div_i   ( div_q    ),
    .busy_o  ( tx_busy  ),
    .tx_o    ( tx_o     )
  );

  uart_rx i_uart_rx (
    .clk_i   ( clk_i   ),
    .reset_i ( reset_i ),
    .rx_i    ( rx_i    ),
    .div_i   ( div_q   ),
    .done_o  ( rx_done ),
    .byte_o  ( rx_byte )
  );

endmodule

//--- hw/uart_rx.sv
`timescale 1ns/1ps

module uart_rx
  import periph_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  rx_i,
  input  div_t  div_i,
  output logic  done_o,
  output byte_t byte_o
);

  rx_state_t  state_q;
  logic       rx_meta_q;
  logic       rx_sync_q;
  logic       rx_prev_q;
  div_t       cnt_q;
  logic [2:0] bit_q;
  byte_t      shift_q;
  logic       half_end;
  logic       bit_end;
  logic       fall;

  // half a bit for the start check, full bit between samples
  assign half_end = (cnt_q == (div_i >> 1) - 16'd1);
  assign bit_end  = (cnt_q == div_i - 16'd1);
  assign fall     = rx_prev_q & ~rx_sync_q;

  // --------------------
  // sync and fsm
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // line idles high
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_q     <= '0;
      done_o    <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
      done_o    <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          if (fall) begin
            state_q <= RX_START;
            cnt_q   <= '0;
          end
        end
        // recheck at mid start bit
        RX_START: begin
          if (half_end) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            // high again means a glitch
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) begin
              state_q <= RX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        // mid stop bit, good frame only if high
        RX_STOP: begin
          if (bit_end) begin
            done_o  <= rx_sync_q;
            state_q <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && bit_end) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign byte_o = shift_q;

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

module uart_tx
  import periph_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  start_i,
  input  byte_t byte_i,
  input  div_t  div_i,
  output logic  busy_o,
  output logic  tx_o
);

  tx_state_t  state_q;
  div_t       cnt_q;
  logic [2:0] bit_q;
  byte_t      shift_q;
  logic       bit_end;

  // last clock of the current bit
  assign bit_end = (cnt_q == div_i - 16'd1);

  // --------------------
  // frame fsm
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= TX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else begin
      case (state_q)
        // start_i only seen here, so ignored while busy
        TX_IDLE: begin
          if (start_i) begin
            state_q <= TX_START;
            cnt_q   <= '0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state_q <= TX_DATA;
            cnt_q   <= '0;
            bit_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            cnt_q <= '0;
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) begin
              state_q <= TX_STOP;
            end
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state_q <= TX_IDLE;
          end else begin
            cnt_q <= cnt_q + 16'd1;
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // shift register, lsb goes out first
  always_ff @(posedge clk_i) begin
    if (state_q == TX_IDLE && start_i) begin
      shift_q <= byte_i;
    end else if (state_q == TX_DATA && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  assign busy_o = (state_q != TX_IDLE);
  // line idles high
  assign tx_o   = (state_q == TX_START) ? 1'b0 :
                  (state_q == TX_DATA)  ? shift_q[0] : 1'b1;

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_periph -f compile.f -o tb_periph_sim

# the log decides pass or fail
./obj_dir/tb_periph_sim 2>&1 | tee sim.log

grep -q "TEST RESULT: PASS" sim.log

//--- testbench/tb_periph.sv
`timescale 1ns/1ps

module tb_periph
  import periph_pkg::*;
();

  logic       clk;
  logic       reset;
  logic       bus_req;
  logic       bus_we;
  addr_t      bus_addr;
  data_t      bus_wdata;
  logic       bus_rvalid;
  data_t      bus_rdata;
  logic       bus_err;
  logic       rx;
  logic       tx;
  logic [1:0] ext_irq;
  logic [1:0] irq;

  // bit time used by the serial line model
  div_t bit_div;

  periph_top DUT (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .bus_req_i    ( bus_req    ),
    .bus_we_i     ( bus_we     ),
    .bus_addr_i   ( bus_addr   ),
    .bus_wdata_i  ( bus_wdata  ),
    .bus_rvalid_o ( bus_rvalid ),
    .bus_rdata_o  ( bus_rdata  ),
    .bus_err_o    ( bus_err    ),
    .rx_i         ( rx         ),
    .tx_o         ( tx         ),
    .ext_irq_i    ( ext_irq    ),
    .irq_o        ( irq        )
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------
  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input data_t exp, input data_t act);
    assert (act === exp) else begin
      $display("** Error: [%s] expected 0x%08h, actual 0x%08h", name, exp, act);
      abort_run();
    end
  endtask

  // one request strobe, response must follow on the next clock
  task automatic bus_access(input string name, input logic we, input addr_t addr,
                            input data_t wdata, output data_t rdata, output logic err);
    @(negedge clk);
    assert (bus_rvalid === 1'b0) else begin
      $display("bus response seen without a request before %s", name);
      abort_run();
    end
    bus_req   = 1'b1;
    bus_we    = we;
    bus_addr  = addr;
    bus_wdata = wdata;
    @(negedge clk);
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    assert (bus_rvalid === 1'b1) else begin
      $display("no bus response one cycle after the request in %s", name);
      abort_run();
    end
    rdata = bus_rdata;
    err   = bus_err;
  endtask

  // mapped write, no error and zero data
  task automatic write_reg(input string name, input addr_t addr, input data_t wdata);
    data_t rd;
    logic  err;
    bus_access(name, 1'b1, addr, wdata, rd, err);
    check_value({name, " err"}, 32'd0, data_t'(err));
    check_value({name, " rdata"}, 32'd0, rd);
  endtask

  task automatic read_reg(input string name, input addr_t addr, output data_t rdata);
    logic err;
    bus_access(name, 1'b0, addr, 32'd0, rdata, err);
    check_value({name, " err"}, 32'd0, data_t'(err));
  endtask

  task automatic wait_irq(input logic tgt, input logic level, input string name);
    int cnt;
    cnt = 0;
    while (irq[tgt] !== level && cnt < 2000) begin
      @(negedge clk);
      cnt++;
    end
    assert (irq[tgt] === level) else begin
      $display("timed out waiting for irq_o[%0d] to become %0b in %s", tgt, level, name);
      abort_run();
    end
  endtask

  // --------------------
  // serial line model
  // --------------------
  // 8n1, lsb first
  task automatic drive_rx_frame(input byte_t b);
    byte_t sh;
    sh = b;
    @(negedge clk);
    rx = 1'b0;
    repeat (bit_div) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = sh[0];
      sh = sh >> 1;
      repeat (bit_div) @(negedge clk);
    end
    rx = 1'b1;
    repeat (bit_div) @(negedge clk);
  endtask

  // start bit found half a clock in, then sample at bit centers
  task automatic capture_tx_frame(output byte_t got);
    int cnt;
    cnt = 0;
    got = '0;
    @(negedge clk);
    while (tx === 1'b1 && cnt < 2000) begin
      @(negedge clk);
      cnt++;
    end
    assert (tx === 1'b0) else begin
      $display("timed out waiting for the tx start bit");
      abort_run();
    end
    repeat (bit_div / 16'd2 - 16'd1) @(negedge clk);
    check_value("tx start bit", 32'd0, data_t'(tx));
    for (int i = 0; i < 8; i++) begin
      repeat (bit_div) @(negedge clk);
      got = {tx, got[7:1]};
    end
    repeat (bit_div) @(negedge clk);
    check_value("tx stop bit", 32'd1, data_t'(tx));
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    data_t       rd;
    logic        err;
    byte_t       tx_byte;
    byte_t       got;
    byte_t       rx_a;
    byte_t       rx_b;
    int          p1;
    int          p2;
    int          p3;
    int          th;
    int          first_id;
    int          second_id;
    int          polls;

    // all inputs idle, reset held for 3 clocks
    reset     = 1'b1;
    bus_req   = 1'b0;
    bus_we    = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    rx        = 1'b1;
    ext_irq   = 2'b00;
    bit_div   = DIV_RESET;
    void'($urandom(16));
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // reset values
    read_reg("reset divisor", UART_BASE + DIV_OFS, rd);
    check_value("reset divisor", 32'd16, rd);
    read_reg("reset status", UART_BASE + STATUS_OFS, rd);
    check_value("reset status", 32'd0, rd);
    check_value("reset irq", 32'd0, data_t'(irq));
    check_value("reset tx line", 32'd1, data_t'(tx));

    // unmapped offsets and regions
    bus_access("uart hole read", 1'b0, UART_BASE + 12'h014, 32'd0, rd, err);
    check_value("uart hole read err", 32'd1, data_t'(err));
    check_value("uart hole read data", 32'd0, rd);
    bus_access("uart hole write", 1'b1, UART_BASE + 12'h014, 32'hFFFF, rd, err);
    check_value("uart hole write err", 32'd1, data_t'(err));
    check_value("uart hole write data", 32'd0, rd);
    bus_access("plic hole read", 1'b0, PLIC_BASE + 12'h0D0, 32'd0, rd, err);
    check_value("plic hole read err", 32'd1, data_t'(err));
    check_value("plic hole read data", 32'd0, rd);
    bus_access("region 0x200 read", 1'b0, 12'h200, 32'd0, rd, err);
    check_value("region 0x200 read err", 32'd1, data_t'(err));
    check_value("region 0x200 read data", 32'd0, rd);
    bus_access("region 0x200 write", 1'b1, 12'h200, 32'h1234, rd, err);
    check_value("region 0x200 write err", 32'd1, data_t'(err));
    check_value("region 0x200 write data", 32'd0, rd);

    // --------------------
    // transmit
    // --------------------
    bit_div = 16'd8;
    write_reg("set divisor", UART_BASE + DIV_OFS, data_t'(bit_div));
    tx_byte = byte_t'($urandom);
    fork
      capture_tx_frame(got);
      begin
        write_reg("txdata write", UART_BASE + TXDATA_OFS, data_t'(tx_byte));
        read_reg("status during tx", UART_BASE + STATUS_OFS, rd);
        check_value("tx busy during frame", 32'd1, data_t'(rd[0]));
        // busy, so this byte is dropped
        write_reg("txdata while busy", UART_BASE + TXDATA_OFS, data_t'(~tx_byte));
      end
    join
    check_value("tx frame byte", data_t'(tx_byte), data_t'(got));

    polls = 0;
    rd    = 32'd1;
    while (rd[0] !== 1'b0 && polls < 100) begin
      read_reg("status poll", UART_BASE + STATUS_OFS, rd);
      polls++;
    end
    assert (rd[0] === 1'b0) else begin
      $display("timed out waiting for the transmitter to go idle");
      abort_run();
    end
    check_value("status after tx", 32'd0, rd);
    // line stays idle, no second frame
    for (int i = 0; i < 30 * int'(bit_div); i++) begin
      @(negedge clk);
      check_value("tx idle after frame", 32'd1, data_t'(tx));
    end

    // --------------------
    // receive
    // --------------------
    rx_a = byte_t'($urandom);
    drive_rx_frame(rx_a);
    read_reg("status rx valid", UART_BASE + STATUS_OFS, rd);
    check_value("status rx valid", 32'd2, rd);
    read_reg("rxdata", UART_BASE + RXDATA_OFS, rd);
    check_value("rxdata", data_t'(rx_a), rd);
    read_reg("status after rxdata", UART_BASE + STATUS_OFS, rd);
    check_value("status after rxdata", 32'd0, rd);

    // two frames, no read in between
    rx_a = byte_t'($urandom);
    rx_b = byte_t'($urandom);
    drive_rx_frame(rx_a);
    drive_rx_frame(rx_b);
    read_reg("status overrun", UART_BASE + STATUS_OFS, rd);
    check_value("status overrun", 32'd6, rd);
    read_reg("rxdata overrun", UART_BASE + RXDATA_OFS, rd);
    check_value("rxdata overrun", data_t'(rx_b), rd);
    read_reg("status after overrun", UART_BASE + STATUS_OFS, rd);
    check_value("status after overrun", 32'd0, rd);

    // --------------------
    // priority routing
    // --------------------
    p2 = 1 + int'($urandom % 7);
    p3 = 1 + int'($urandom % 7);
    write_reg("prio 2", PLIC_BASE + PRIO_OFS + 12'h008, data_t'(p2));
    write_reg("prio 3", PLIC_BASE + PRIO_OFS + 12'h00C, data_t'(p3));
    write_reg("enable t0", PLIC_BASE + ENABLE_OFS, 32'h0000_000C);
    ext_irq = 2'b11;
    wait_irq(1'b0, 1'b1, "ext sources pending");

    // target 1 sees only source 2
    th = p2 + int'($urandom % (8 - p2));
    write_reg("enable t1", PLIC_BASE + ENABLE_OFS + 12'h004, 32'h0000_0004);
    write_reg("threshold t1 high", PLIC_BASE + THRESH_OFS + 12'h004, data_t'(th));
    check_value("irq t1 under threshold", 32'd0, data_t'(irq[1]));
    write_reg("threshold t1 low", PLIC_BASE + THRESH_OFS + 12'h004, data_t'(p2 - 1));
    check_value("irq t1 over threshold", 32'd1, data_t'(irq[1]));
    write_reg("enable t1 off", PLIC_BASE + ENABLE_OFS + 12'h004, 32'd0);
    write_reg("threshold t1 clear", PLIC_BASE + THRESH_OFS + 12'h004, 32'd0);

    // higher priority wins, lower id on a tie
    first_id  = (p3 > p2) ? 3 : 2;
    second_id = (first_id == 3) ? 2 : 3;
    read_reg("first claim", PLIC_BASE + CLAIM_OFS, rd);
    check_value("first claim", data_t'(first_id), rd);
    check_value("irq t0 second pending", 32'd1, data_t'(irq[0]));

    // --------------------
    // claim and complete
    // --------------------
    read_reg("second claim", PLIC_BASE + CLAIM_OFS, rd);
    check_value("second claim", data_t'(second_id), rd);
    check_value("irq t0 all in service", 32'd0, data_t'(irq[0]));
    repeat (4) @(negedge clk);
    check_value("irq t0 still low", 32'd0, data_t'(irq[0]));
    read_reg("empty claim", PLIC_BASE + CLAIM_OFS, rd);
    check_value("empty claim", 32'd0, rd);

    // completion lets the still high source back in
    write_reg("complete first", PLIC_BASE + CLAIM_OFS, data_t'(first_id));
    wait_irq(1'b0, 1'b1, "pending again after complete");
    read_reg("claim after complete", PLIC_BASE + CLAIM_OFS, rd);
    check_value("claim after complete", data_t'(first_id), rd);

    ext_irq = 2'b00;
    write_reg("complete first again", PLIC_BASE + CLAIM_OFS, data_t'(first_id));
    write_reg("complete second", PLIC_BASE + CLAIM_OFS, data_t'(second_id));
    write_reg("enable t0 off", PLIC_BASE + ENABLE_OFS, 32'd0);
    repeat (2) @(negedge clk);
    check_value("irq after cleanup", 32'd0, data_t'(irq));

    // --------------------
    // uart interrupt path
    // --------------------
    p1 = 1 + int'($urandom % 7);
    write_reg("irqen", UART_BASE + IRQEN_OFS, 32'd1);
    write_reg("prio 1", PLIC_BASE + PRIO_OFS + 12'h004, data_t'(p1));
    write_reg("enable t1 uart", PLIC_BASE + ENABLE_OFS + 12'h004, 32'h0000_0002);
    rx_a = byte_t'($urandom);
    drive_rx_frame(rx_a);
    wait_irq(1'b1, 1'b1, "uart rx interrupt");
    read_reg("uart claim", PLIC_BASE + CLAIM_OFS + 12'h004, rd);
    check_value("uart claim", 32'd1, rd);
    read_reg("uart rxdata", UART_BASE + RXDATA_OFS, rd);
    check_value("uart rxdata", data_t'(rx_a), rd);
    write_reg("uart complete", PLIC_BASE + CLAIM_OFS + 12'h004, 32'd1);
    repeat (4) @(negedge clk);
    check_value("irq t1 after complete", 32'd0, data_t'(irq[1]));
    check_value("irq at end", 32'd0, data_t'(irq));

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
